// File: tests/testdata_program.hex
// header: program words, expected stores, expected stall cycles
// then the program words, then one expected store per line as address and data
0000002B 00000013 00000002
// $1 = 100, $2 = -7, $3 = $1 + $2, store $3
20010064 2002FFF9 00221820 AC030100
// sub addu subu and or slt sltu
00222022 00212821 00413023 00223824 00224025 0041482A 0025502B
// ori lui slt
342B8001 3C0C1234 0022682A
// store $4 to $13
AC040104 AC050108 AC06010C AC070110 AC080114
AC090118 AC0A011C AC0B0120 AC0C0124 AC0D0128
// addiu, then users at distance one, two and three
258E0010 01CE7820 21D00001 01C08825 AC0F012C AC100130 AC110134
// store, load back, dependent addi, store again
AC030138 8C120138 22530005 AC13013C
// load then store of it, load then independent then user
8C140104 AC140140 8C150108 20160003 02B6B822 AC170144
// write to r0, store r0
20000055 AC000148
// expected stores
00000100 0000005D
00000104 0000006B
00000108 000000C8
0000010C FFFFFF95
00000110 00000060
00000114 FFFFFFFD
00000118 00000001
0000011C 00000001
00000120 00008065
00000124 12340000
00000128 00000000
0000012C 24680020
00000130 12340011
00000134 12340010
00000138 0000005D
0000013C 00000062
00000140 0000006B
00000144 000000C5
00000148 00000000

// File: src.f
rtl/mips_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/mips_pipeline.sv
tests/mips_pipeline_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module mips_pipeline_tb -f src.f -o mips_pipeline_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/mips_pipeline_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" "$log"; then
  exit 1
fi
exit 0

// File: tests/mips_pipeline_tb.sv
`default_nettype none

module mips_pipeline_tb
  import mips_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int tdata_depth    = 256;
  localparam int dmem_depth     = 256;
  localparam int hdr_words      = 3;    // length, stores, stalls
  localparam int timeout_cycles = 400;
  localparam int drain_cycles   = 8;

  logic  clk;
  logic  reset;
  word_t instr;
  word_t pc;
  logic  mem_write;
  word_t mem_addr;
  word_t mem_write_data;
  word_t mem_read_data;

  word_t tdata [tdata_depth];
  word_t dmem  [dmem_depth];

  int    prog_len;
  int    store_count;
  int    stall_expected;
  int    store_idx;
  int    stall_count;
  int    check_total;
  int    error_count;
  int    fail_count;
  word_t prev_pc;
  logic  pc_seen;

  mips_pipeline dut_i (
    .clk            (clk),
    .reset          (reset),
    .instr          (instr),
    .pc             (pc),
    .mem_write      (mem_write),
    .mem_addr       (mem_addr),
    .mem_write_data (mem_write_data),
    .mem_read_data  (mem_read_data)
  );

  initial
    clk = 1'b0;

  always #5 clk = ~clk;

  // ------------------------------
  // memory models
  // ------------------------------
  always_comb
  begin
    instr = '0;  // nop past the program
    if ((pc >> 2) < word_t'(prog_len))
      instr = tdata[8'(word_t'(hdr_words) + (pc >> 2))];
  end

  always @(posedge clk)
  begin
    if (mem_write)
      dmem[mem_addr[9:2]] <= mem_write_data;
    mem_read_data <= dmem[mem_addr[9:2]];  // one cycle read latency
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_word(input string name, input word_t expected, input word_t actual);
    check_total++;
    if (actual !== expected)
    begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    check_total++;
    if (actual != expected)
    begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_store;
    word_t exp_addr;
    word_t exp_data;
    if (store_idx < store_count)
    begin
      exp_addr = tdata[8'(hdr_words + prog_len + 2 * store_idx)];
      exp_data = tdata[8'(hdr_words + prog_len + 2 * store_idx + 1)];
      check_word($sformatf("store %0d address", store_idx), exp_addr, mem_addr);
      check_word($sformatf("store %0d data", store_idx), exp_data, mem_write_data);
    end
    else
    begin
      $display("unexpected extra store of %h to address %h", mem_write_data, mem_addr);
      fail_count++;
    end
    store_idx++;
  endtask

  // outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk)
  begin
    if (reset)
    begin
      check_word("pc in reset", reset_pc, pc);
      check_word("mem_write in reset", '0, word_t'(mem_write));
      pc_seen = 1'b0;
    end
    else
    begin
      if (!pc_seen)
      begin
        check_word("pc after reset", reset_pc, pc);
        check_word("mem_write after reset", '0, word_t'(mem_write));
      end
      else if (pc == prev_pc)
        stall_count++;  // load-use bubble
      else
        check_word("pc step", prev_pc + pc_step, pc);
      pc_seen = 1'b1;
      if (mem_write)
        check_store();
    end
    prev_pc = pc;
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial
  begin
    int cycles;
    reset         = 1'b1;
    mem_read_data = '0;
    store_idx     = 0;
    stall_count   = 0;
    check_total   = 0;
    error_count   = 0;
    fail_count    = 0;
    pc_seen       = 1'b0;
    prev_pc       = '0;
    $readmemh("tests/testdata_program.hex", tdata);
    prog_len       = tdata[0];
    store_count    = tdata[1];
    stall_expected = tdata[2];
    for (int i = 0; i < dmem_depth; i++)
      dmem[i[7:0]] <= 32'hdada_0000 ^ (word_t'(i) << 2);

    repeat (10) @(posedge clk);
    reset <= 1'b0;

    cycles = 0;
    while (store_idx < store_count && cycles < timeout_cycles)
    begin
      @(posedge clk);
      cycles++;
    end
    if (store_idx < store_count)
    begin
      $display("timeout: only %0d of %0d stores seen after %0d cycles",
               store_idx, store_count, cycles);
      fail_count++;
    end

    repeat (drain_cycles) @(posedge clk);  // a stray late store would show here
    check_count("stall cycles", stall_expected, stall_count);
    check_count("store count", store_count, store_idx);

    $display("%0d checks, %0d wrong values, %0d other failures",
             check_total, error_count, fail_count);
    if (error_count == 0 && fail_count == 0)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/mips_pipeline.sv
`default_nettype none

module mips_pipeline
  import mips_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  word_t instr,
  output word_t pc,
  output logic  mem_write,
  output word_t mem_addr,
  output word_t mem_write_data,
  input  word_t mem_read_data
);

  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  wb_t       wb;
  reg_addr_t ex_load_dest;

  decode_stage decode_i (
    .clk          (clk),
    .reset        (reset),
    .instr        (instr),
    .wb           (wb),
    .ex_load_dest (ex_load_dest),
    .pc           (pc),
    .id_ex        (id_ex)
  );

  execute_stage execute_i (
    .clk          (clk),
    .reset        (reset),
    .id_ex        (id_ex),
    .wb           (wb),
    .ex_mem       (ex_mem),
    .ex_load_dest (ex_load_dest)
  );

  result_stage result_i (
    .clk           (clk),
    .reset         (reset),
    .ex_mem        (ex_mem),
    .mem_read_data (mem_read_data),
    .wb            (wb)
  );

  // data memory port
  assign mem_write      = ex_mem.mem_write;
  assign mem_addr       = ex_mem.alu_out;
  assign mem_write_data = ex_mem.store_data;

endmodule

`default_nettype wire

// File: rtl/result_stage.sv
`default_nettype none

module result_stage
  import mips_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  ex_mem_t ex_mem,
  input  word_t   mem_read_data,
  output wb_t     wb
);

  wb_t  wb_q;         // value holds the alu result
  logic mem_to_reg_q;

  // ------------------------------
  // MEM/WB
  // ------------------------------
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wb_q         <= '0;
      mem_to_reg_q <= 1'b0;
    end
    else
    begin
      wb_q.reg_write <= ex_mem.reg_write;
      wb_q.dest      <= ex_mem.dest;
      wb_q.value     <= ex_mem.alu_out;
      mem_to_reg_q   <= ex_mem.mem_to_reg;
    end
  end

  // read data arrives registered from the data memory, aligned with MEM/WB
  always_comb
  begin
    wb = wb_q;
    if (mem_to_reg_q)
      wb.value = mem_read_data;
  end

  no_load_and_store: assert property (@(posedge clk) disable iff (reset)
    !(ex_mem.mem_write && ex_mem.mem_to_reg));

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`default_nettype none

module execute_stage
  import mips_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  id_ex_t    id_ex,
  input  wb_t       wb,
  output ex_mem_t   ex_mem,
  output reg_addr_t ex_load_dest
);

  ex_mem_t   mem_fwd;
  word_t     src_a;
  word_t     fwd_b;
  word_t     src_b;
  word_t     alu_out;
  reg_addr_t dest;

  // ------------------------------
  // forwarding, mem over wb
  // ------------------------------
  function automatic word_t forward(reg_addr_t src, word_t id_val, ex_mem_t m, wb_t w);
    word_t val;
    val = id_val;
    if (m.reg_write && m.dest != '0 && m.dest == src)
      val = m.alu_out;
    else if (w.reg_write && w.dest != '0 && w.dest == src)
      val = w.value;
    return val;
  endfunction

  assign src_a = forward(id_ex.rs, id_ex.rs_val, mem_fwd, wb);
  assign fwd_b = forward(id_ex.rt, id_ex.rt_val, mem_fwd, wb);
  assign src_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;

  always_comb
  begin
    case (id_ex.ctrl.alu_op)
      alu_and: alu_out = src_a & src_b;
      alu_or:  alu_out = src_a | src_b;
      alu_sub: alu_out = src_a - src_b;
      alu_slt: alu_out = {31'b0, $signed(src_a) < $signed(src_b)};  // sltu too
      default: alu_out = src_a + src_b;
    endcase
  end

  assign dest = id_ex.ctrl.reg_dst ? id_ex.dest : id_ex.rt;

  // seen by decode for the load-use check
  assign ex_load_dest = id_ex.ctrl.mem_to_reg ? dest : '0;

  // ------------------------------
  // EX/MEM
  // ------------------------------
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mem_fwd <= '0;
    else
    begin
      mem_fwd.reg_write  <= id_ex.ctrl.reg_write;
      mem_fwd.mem_to_reg <= id_ex.ctrl.mem_to_reg;
      mem_fwd.mem_write  <= id_ex.ctrl.mem_write;
      mem_fwd.alu_out    <= alu_out;
      mem_fwd.store_data <= fwd_b;
      mem_fwd.dest       <= dest;
    end
  end

  assign ex_mem = mem_fwd;

  // decode only ever emits the five encodings or a zero bubble
  alu_op_legal: assert property (@(posedge clk) disable iff (reset)
    id_ex.ctrl.alu_op inside {alu_and, alu_or, alu_add, alu_sub, alu_slt});

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none

module decode_stage
  import mips_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  word_t     instr,
  input  wb_t       wb,
  input  reg_addr_t ex_load_dest,
  output word_t     pc,
  output id_ex_t    id_ex
);

  word_t       if_id_instr;
  logic [5:0]  opcode;
  logic [5:0]  funct;
  logic [15:0] imm16;
  reg_addr_t   rs;
  reg_addr_t   rt;
  word_t       rs_val;
  word_t       rt_val;
  word_t       imm;
  ctrl_t       ctrl;
  logic        stall;

  assign opcode = if_id_instr[31:26];
  assign funct  = if_id_instr[5:0];
  assign imm16  = if_id_instr[15:0];
  assign rs     = if_id_instr[rs_lsb +: 5];
  assign rt     = if_id_instr[rt_lsb +: 5];

  // ------------------------------
  // fetch: pc and IF/ID
  // ------------------------------
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pc          <= reset_pc;
      if_id_instr <= '0;
    end
    else if (!stall)
    begin
      pc          <= pc + pc_step;
      if_id_instr <= instr;
    end
  end

  reg_file rf_i (
    .clk   (clk),
    .reset (reset),
    .ra1   (rs),
    .ra2   (rt),
    .wb    (wb),
    .rd1   (rs_val),
    .rd2   (rt_val)
  );

  // ------------------------------
  // main and alu decode
  // ------------------------------
  always_comb
  begin
    ctrl = '0;
    ctrl.alu_op = alu_add;
    imm = {{16{imm16[15]}}, imm16};
    case (opcode)
      op_rtype:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = 1'b1;
        case (funct)
          funct_add, funct_addu: ctrl.alu_op = alu_add;
          funct_sub, funct_subu: ctrl.alu_op = alu_sub;
          funct_and:             ctrl.alu_op = alu_and;
          funct_or:              ctrl.alu_op = alu_or;
          funct_slt, funct_sltu: ctrl.alu_op = alu_slt;
          default:               ctrl.reg_write = 1'b0;  // add into r0
        endcase
      end
      op_lw:
      begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
      end
      op_sw:
      begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      op_addi, op_addiu:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      op_ori:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = alu_or;
        imm            = {16'b0, imm16};
      end
      op_lui:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        imm            = {imm16, 16'b0};  // rs is r0, so add gives imm
      end
      default: ;  // unknown op acts as nop
    endcase
  end

  // load-use hazard
  assign stall = (ex_load_dest != '0) && (ex_load_dest == rs || ex_load_dest == rt);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      id_ex <= '0;
    else
    begin
      id_ex.ctrl   <= stall ? ctrl_t'('0) : ctrl;  // bubble
      id_ex.rs_val <= rs_val;
      id_ex.rt_val <= rt_val;
      id_ex.imm    <= imm;
      id_ex.rs     <= rs;
      id_ex.rt     <= rt;
      id_ex.dest   <= if_id_instr[rd_lsb +: 5];
    end
  end

  // the bubble clears ex_load_dest, so a stall never repeats
  stall_single_cycle: assert property (@(posedge clk) disable iff (reset) stall |=> !stall);

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none

module reg_file
  import mips_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  input  wb_t       wb,
  output word_t     rd1,
  output word_t     rd2
);

  word_t regs [reg_count];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < reg_count; i++)
        regs[i] <= '0;
    end
    else if (wb.reg_write && wb.dest != '0)
      regs[wb.dest] <= wb.value;
  end

  // write-before-read, r0 hardwired
  assign rd1 = (ra1 == '0) ? '0 :
               (wb.reg_write && wb.dest == ra1) ? wb.value : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 :
               (wb.reg_write && wb.dest == ra2) ? wb.value : regs[ra2];

endmodule

`default_nettype wire

// File: rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // ------------------------------
  // opcodes and functs
  // ------------------------------
  localparam logic [5:0] op_rtype = 6'b000000;
  localparam logic [5:0] op_lw    = 6'b100011;
  localparam logic [5:0] op_sw    = 6'b101011;
  localparam logic [5:0] op_addi  = 6'b001000;
  localparam logic [5:0] op_addiu = 6'b001001;
  localparam logic [5:0] op_ori   = 6'b001101;
  localparam logic [5:0] op_lui   = 6'b001111;

  localparam logic [5:0] funct_add  = 6'b100000;
  localparam logic [5:0] funct_addu = 6'b100001;
  localparam logic [5:0] funct_sub  = 6'b100010;
  localparam logic [5:0] funct_subu = 6'b100011;
  localparam logic [5:0] funct_and  = 6'b100100;
  localparam logic [5:0] funct_or   = 6'b100101;
  localparam logic [5:0] funct_slt  = 6'b101010;
  localparam logic [5:0] funct_sltu = 6'b101011;

  localparam int rs_lsb = 21;
  localparam int rt_lsb = 16;
  localparam int rd_lsb = 11;

  localparam word_t pc_step   = 32'd4;
  localparam word_t reset_pc  = 32'd0;
  localparam int    reg_count = 32;

  typedef enum logic [2:0] {
    alu_and = 3'b000,
    alu_or  = 3'b001,
    alu_add = 3'b010,
    alu_sub = 3'b110,
    alu_slt = 3'b111
  } alu_op_e;

  // ------------------------------
  // pipeline payloads
  // ------------------------------
  typedef struct packed {
    logic    reg_write;
    logic    mem_to_reg;
    logic    mem_write;
    logic    alu_src;  // 1: immediate as operand b
    logic    reg_dst;  // 1: rd, 0: rt
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     rs_val;
    word_t     rt_val;
    word_t     imm;     // extended, lui already shifted
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dest;    // rd field
  } id_ex_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_to_reg;
    logic      mem_write;
    word_t     alu_out;
    word_t     store_data;
    reg_addr_t dest;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    reg_addr_t dest;
    word_t     value;
  } wb_t;

endpackage

`default_nettype wire
